//--- Makefile
TOP := tb_eeprom

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f eeprom_if.f -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

lint:
	verilator --lint-only -Wall --top-module eeprom_if_top \
	  src/eeprom_pkg.sv src/i2c_bit_engine.sv src/i2c_byte_shift.sv \
	  src/eeprom_seq.sv src/eeprom_if_top.sv

clean:
	rm -rf obj_dir

//--- eeprom_if.f
src/eeprom_pkg.sv
src/i2c_bit_engine.sv
src/i2c_byte_shift.sv
src/eeprom_seq.sv
src/eeprom_if_top.sv
sim/tb_clk_gen.sv
sim/eeprom_model.sv
sim/eeprom_sva.sv
sim/tb_eeprom.sv

//--- sim/eeprom_model.sv
`timescale 1ns/10ps
`default_nettype none

// 24C16 style slave, single byte write and random read only
module eeprom_model (
  input  logic scl,
  input  logic sda,
  input  logic enable,   // when low the part never acks
  output logic sda_pull
);

  logic [7:0] mem [0:2047];
  logic [7:0] shreg;
  logic [2:0] block;
  logic [7:0] ptr;
  logic       prev_scl;
  logic       prev_sda;
  logic       active;
  logic       tx_mode;
  logic       go_tx;
  logic       acked;
  int         bcnt;       // scl rises seen in this byte, 9 = ack slot done
  int         byte_idx;

  initial begin
    for (int a = 0; a < 2048; a++)
      mem[a] = 8'hFF;   // blank part
    sda_pull = 1'b0;
    prev_scl = 1'b1;
    prev_sda = 1'b1;
    active   = 1'b0;
    tx_mode  = 1'b0;
    go_tx    = 1'b0;
    bcnt     = 0;
    byte_idx = 0;
  end

  always @(scl or sda) begin
    if (scl && prev_scl && prev_sda && !sda) begin
      active   = 1'b1;  // start or repeated start
      tx_mode  = 1'b0;
      go_tx    = 1'b0;
      bcnt     = 0;
      byte_idx = 0;
      sda_pull = 1'b0;
    end else if (scl && prev_scl && !prev_sda && sda) begin
      active   = 1'b0;  // stop
      sda_pull = 1'b0;
    end else if (active && scl && !prev_scl) begin
      if (!tx_mode && bcnt < 8)
        shreg = {shreg[6:0], sda};
      bcnt++;
    end else if (active && !scl && prev_scl) begin
      if (tx_mode) begin
        if (bcnt < 8) begin
          sda_pull = !shreg[7 - bcnt];
        end else begin
          sda_pull = 1'b0;  // master acks, then one byte only
          if (bcnt == 9)
            active = 1'b0;
        end
      end else if (bcnt == 8) begin
        acked = 1'b0;
        case (byte_idx)
          0: if (enable && shreg[7:4] == 4'b1010) begin
            acked = 1'b1;
            block = shreg[3:1];
            go_tx = shreg[0];
          end
          1: if (enable) begin
            acked = 1'b1;
            ptr   = shreg;
          end
          default: if (enable) begin
            acked = 1'b1;
            mem[{block, ptr}] = shreg;
            ptr   = ptr + 8'd1;
          end
        endcase
        byte_idx++;
        sda_pull = acked;
      end else if (bcnt == 9) begin
        sda_pull = 1'b0;
        bcnt     = 0;
        if (go_tx) begin
          tx_mode  = 1'b1;
          shreg    = mem[{block, ptr}];
          sda_pull = !shreg[7];
        end
      end
    end
    prev_scl = scl;
    prev_sda = sda;
  end

endmodule

`default_nettype wire

//--- sim/eeprom_sva.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_sva (
  input logic                clk,
  input logic                arst_n,
  input logic                scl,
  input logic                sda_pull,
  input logic                sda_in,
  input eeprom_pkg::bit_op_t bit_op,
  input logic                req_valid,
  input logic                req_ready,
  input logic                rsp_valid
);

  logic busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      busy <= 1'b0;
    else if (req_valid && req_ready)
      busy <= 1'b1;
    else if (rsp_valid)
      busy <= 1'b0;
  end

  // with scl high only the master moves sda, and only for a start or stop
  a_sda_owner: assert property (@(posedge clk) disable iff (!arst_n)
    (scl && $past(scl) && sda_in != $past(sda_in)) |->
      ((sda_pull != $past(sda_pull)) &&
       ($past(bit_op) == eeprom_pkg::BIT_START ||
        $past(bit_op) == eeprom_pkg::BIT_STOP)))
    else $error("sda moved while scl high outside start or stop");

  a_start_hold: assert property (@(posedge clk) disable iff (!arst_n)
    ($fell(sda_in) && scl && $past(scl)) |=> !sda_in)
    else $error("start not held");

  a_stop_idle: assert property (@(posedge clk) disable iff (!arst_n)
    ($rose(sda_in) && scl && $past(scl)) |=> (scl && sda_in))
    else $error("bus not idle after stop");

  a_rsp_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid |=> !rsp_valid)
    else $error("rsp_valid longer than one cycle");

  a_ready_busy: assert property (@(posedge clk) disable iff (!arst_n)
    busy |-> !req_ready)
    else $error("req_ready high during transaction");

endmodule

bind eeprom_if_top eeprom_sva i_eeprom_sva (
  .clk       (clk),
  .arst_n    (arst_n),
  .scl       (scl),
  .sda_pull  (sda_pull),
  .sda_in    (sda_in),
  .bit_op    (bit_op),
  .req_valid (req_valid),
  .req_ready (req_ready),
  .rsp_valid (rsp_valid)
);

`default_nettype wire

//--- sim/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 16
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #10 arst_n = 1'b1;  // released off the edge
  end

endmodule

`default_nettype wire

//--- sim/tb_eeprom.sv
`timescale 1ns/10ps
`default_nettype none

module tb_eeprom;

  localparam int unsigned CLK_DIV = 4;
  localparam int    PERIOD = 100;
  localparam int    N      = 14;
  localparam int    WR_LAT = 29 * 4 * CLK_DIV + 7;
  localparam int    RD_LAT = 39 * 4 * CLK_DIV + 9;
  localparam longint WD_NS = longint'(N) * RD_LAT * 2 * PERIOD + 20 * PERIOD;

  logic                 clk;
  logic                 arst_n;
  logic                 req_valid;
  logic                 req_ready;
  logic                 req_write;
  eeprom_pkg::ee_addr_t req_addr;
  eeprom_pkg::ee_byte_t req_wdata;
  logic                 rsp_valid;
  eeprom_pkg::ee_byte_t rsp_rdata;
  logic                 rsp_nack;
  logic                 scl;
  logic                 sda_pull;
  logic                 model_pull;
  logic                 model_en;
  wire                  sda;

  // stimulus table
  logic                 tbl_wr   [N];
  eeprom_pkg::ee_addr_t tbl_addr [N];
  eeprom_pkg::ee_byte_t tbl_data [N];
  logic                 tbl_on   [N];
  logic                 tbl_nack [N];
  logic [7:0]           sb       [0:2047];
  integer               seed;

  assign sda = !(sda_pull || model_pull);  // wired and with pull-up

  tb_clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(16)) i_tb_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  eeprom_if_top #(.CLK_DIV(CLK_DIV)) i_eeprom_if_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .rsp_nack  (rsp_nack),
    .scl       (scl),
    .sda_pull  (sda_pull),
    .sda_in    (sda)
  );

  eeprom_model i_eeprom_model (
    .scl      (scl),
    .sda      (sda),
    .enable   (model_en),
    .sda_pull (model_pull)
  );

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error @ %0t: %s expected %0h, got %0h", $time, name, exp, act);
      $display("Result: FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic add_entry(input int i, input logic wr, input eeprom_pkg::ee_addr_t a,
                           input logic on, input logic nk);
    tbl_wr[i]   = wr;
    tbl_addr[i] = a;
    tbl_data[i] = 8'($random(seed));
    tbl_on[i]   = on;
    tbl_nack[i] = nk;
  endtask

  task automatic run_entry(input int i);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #10;
    model_en  = tbl_on[i];
    req_write = tbl_wr[i];
    req_addr  = tbl_addr[i];
    req_wdata = tbl_data[i];
    req_valid = 1'b1;  // held high for the whole transaction
    do @(negedge clk); while (!req_ready);
    do begin
      @(negedge clk);
      cycles++;
      check("req_ready", 32'd0, 32'(req_ready));
    end while (!rsp_valid);
    check("rsp_nack", 32'(tbl_nack[i]), 32'(rsp_nack));
    if (!tbl_nack[i]) begin
      if (tbl_wr[i]) begin
        sb[tbl_addr[i]] = tbl_data[i];
        check("write latency", 32'(WR_LAT), 32'(cycles));
      end else begin
        check("rsp_rdata", 32'(sb[tbl_addr[i]]), 32'(rsp_rdata));
        check("read latency", 32'(RD_LAT), 32'(cycles));
      end
    end
    @(posedge clk);
    #10 req_valid = 1'b0;
  endtask

  initial begin
    #(WD_NS);
    $display("watchdog expired, DUT stopped responding");
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    model_en  = 1'b1;
    seed      = 11;
    for (int a = 0; a < 2048; a++)
      sb[a] = 8'hFF;  // erased part
    add_entry(0,  1'b1, 11'h012, 1'b1, 1'b0);
    add_entry(1,  1'b0, 11'h012, 1'b1, 1'b0);
    add_entry(2,  1'b1, 11'h345, 1'b1, 1'b0);
    add_entry(3,  1'b0, 11'h345, 1'b1, 1'b0);
    add_entry(4,  1'b1, 11'h7A9, 1'b1, 1'b0);
    add_entry(5,  1'b0, 11'h7A9, 1'b1, 1'b0);
    add_entry(6,  1'b0, 11'h100, 1'b1, 1'b0);
    add_entry(7,  1'b0, 11'h6FF, 1'b1, 1'b0);
    add_entry(8,  1'b1, 11'h345, 1'b1, 1'b0);  // overwrite
    add_entry(9,  1'b0, 11'h345, 1'b1, 1'b0);
    add_entry(10, 1'b1, 11'h200, 1'b0, 1'b1);  // part switched off
    add_entry(11, 1'b0, 11'h200, 1'b0, 1'b1);
    add_entry(12, 1'b0, 11'h012, 1'b1, 1'b0);
    add_entry(13, 1'b0, 11'h200, 1'b1, 1'b0);  // nacked write left no trace
    tbl_data[8] = ~tbl_data[2];  // new value always differs from the old one

    @(posedge arst_n);
    @(negedge clk);
    check("req_ready", 32'd1, 32'(req_ready));
    check("scl", 32'd1, 32'(scl));
    check("sda_pull", 32'd0, 32'(sda_pull));
    check("rsp_valid", 32'd0, 32'(rsp_valid));

    for (int i = 0; i < N; i++)
      run_entry(i);

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/eeprom_if_top.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_if_top #(
  parameter int unsigned CLK_DIV = 4  // clk cycles per quarter scl period
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  logic                 req_write,
  input  eeprom_pkg::ee_addr_t req_addr,
  input  eeprom_pkg::ee_byte_t req_wdata,
  output logic                 rsp_valid,
  output eeprom_pkg::ee_byte_t rsp_rdata,
  output logic                 rsp_nack,
  output logic                 scl,
  output logic                 sda_pull,
  input  logic                 sda_in
);

  logic                 byte_go;
  eeprom_pkg::bit_op_t  byte_op;
  eeprom_pkg::ee_byte_t byte_tx;
  logic                 byte_done;
  eeprom_pkg::ee_byte_t byte_rx;
  logic                 ack_seen;
  logic                 bit_go;
  eeprom_pkg::bit_op_t  bit_op;
  logic                 bit_tx;
  logic                 bit_done;
  logic                 bit_rx;

  eeprom_seq i_eeprom_seq (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .rsp_nack  (rsp_nack),
    .byte_go   (byte_go),
    .byte_op   (byte_op),
    .byte_tx   (byte_tx),
    .byte_done (byte_done),
    .byte_rx   (byte_rx),
    .ack_seen  (ack_seen)
  );

  i2c_byte_shift i_i2c_byte_shift (
    .clk       (clk),
    .arst_n    (arst_n),
    .byte_go   (byte_go),
    .byte_op   (byte_op),
    .byte_tx   (byte_tx),
    .byte_done (byte_done),
    .byte_rx   (byte_rx),
    .ack_seen  (ack_seen),
    .bit_go    (bit_go),
    .bit_op    (bit_op),
    .bit_tx    (bit_tx),
    .bit_done  (bit_done),
    .bit_rx    (bit_rx)
  );

  i2c_bit_engine #(
    .CLK_DIV (CLK_DIV)
  ) i_i2c_bit_engine (
    .clk      (clk),
    .arst_n   (arst_n),
    .bit_go   (bit_go),
    .bit_op   (bit_op),
    .bit_tx   (bit_tx),
    .bit_done (bit_done),
    .bit_rx   (bit_rx),
    .scl      (scl),
    .sda_pull (sda_pull),
    .sda_in   (sda_in)
  );

endmodule

`default_nettype wire

//--- src/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

  // 24C16 style part: 2 KB, block select rides in the control byte
  typedef logic [10:0] ee_addr_t;   // [10:8] block, [7:0] word address
  typedef logic [7:0]  ee_byte_t;   // data, control or word-address byte

  // bus operation code, shared by the byte and bit levels
  typedef logic [1:0] bit_op_t;

  localparam bit_op_t BIT_START = 2'd0;  // start or repeated start
  localparam bit_op_t BIT_STOP  = 2'd1;
  localparam bit_op_t BIT_WRITE = 2'd2;  // master drives sda
  localparam bit_op_t BIT_READ  = 2'd3;  // master releases sda, samples

  // fixed upper nibble of the control byte
  localparam logic [3:0] DEV_CODE = 4'b1010;

endpackage

`default_nettype wire

//--- src/eeprom_seq.sv
`timescale 1ns/10ps
`default_nettype none

module eeprom_seq (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  logic                 req_write,
  input  eeprom_pkg::ee_addr_t req_addr,
  input  eeprom_pkg::ee_byte_t req_wdata,
  output logic                 rsp_valid,
  output eeprom_pkg::ee_byte_t rsp_rdata,
  output logic                 rsp_nack,
  output logic                 byte_go,
  output eeprom_pkg::bit_op_t  byte_op,
  output eeprom_pkg::ee_byte_t byte_tx,
  input  logic                 byte_done,
  input  eeprom_pkg::ee_byte_t byte_rx,
  input  logic                 ack_seen
);

  // bit 0 of byte_tx is the ack we return after a receive, 1 = nack
  localparam eeprom_pkg::ee_byte_t RX_LAST = 8'h01;

  typedef enum logic [3:0] {
    S_IDLE,
    S_START,
    S_CTRL_WR,
    S_WORD_ADDR,
    S_WR_DATA,
    S_RSTART,
    S_CTRL_RD,
    S_RD_DATA,
    S_STOP,
    S_RESPOND
  } state_t;

  state_t               state;
  logic                 write_q;
  eeprom_pkg::ee_addr_t addr_q;
  eeprom_pkg::ee_byte_t wdata_q;
  eeprom_pkg::ee_byte_t ctrl_wr;
  eeprom_pkg::ee_byte_t ctrl_rd;
  logic                 req_take;
  logic                 nack_stop;

  assign req_ready = (state == S_IDLE) && !rsp_valid;  // rsp cycle counts as busy
  assign req_take  = req_valid && req_ready;

  assign ctrl_wr = {eeprom_pkg::DEV_CODE, addr_q[10:8], 1'b0};
  assign ctrl_rd = {eeprom_pkg::DEV_CODE, addr_q[10:8], 1'b1};

  // any byte we sent that the slave did not ack ends the transfer
  assign nack_stop = byte_done && !ack_seen &&
                     (state == S_CTRL_WR || state == S_WORD_ADDR ||
                      state == S_WR_DATA || state == S_CTRL_RD);

  always_ff @(posedge clk) begin
    if (req_take) begin
      write_q <= req_write;
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
    if (state == S_RD_DATA && byte_done)
      rsp_rdata <= byte_rx;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_IDLE;
      byte_go   <= 1'b0;
      byte_op   <= eeprom_pkg::BIT_STOP;
      byte_tx   <= '0;
      rsp_valid <= 1'b0;
      rsp_nack  <= 1'b0;
    end else begin
      byte_go   <= 1'b0;
      rsp_valid <= 1'b0;
      if (nack_stop) begin
        rsp_nack <= 1'b1;
        state    <= S_STOP;
        byte_go  <= 1'b1;
        byte_op  <= eeprom_pkg::BIT_STOP;
      end else begin
        case (state)
          S_IDLE: if (req_take) begin
            rsp_nack <= 1'b0;
            state    <= S_START;
            byte_go  <= 1'b1;
            byte_op  <= eeprom_pkg::BIT_START;
          end
          S_START: if (byte_done) begin
            state   <= S_CTRL_WR;
            byte_go <= 1'b1;
            byte_op <= eeprom_pkg::BIT_WRITE;
            byte_tx <= ctrl_wr;  // dummy write sets the address for reads too
          end
          S_CTRL_WR: if (byte_done) begin
            state   <= S_WORD_ADDR;
            byte_go <= 1'b1;
            byte_op <= eeprom_pkg::BIT_WRITE;
            byte_tx <= addr_q[7:0];
          end
          S_WORD_ADDR: if (byte_done) begin
            byte_go <= 1'b1;
            if (write_q) begin
              state   <= S_WR_DATA;
              byte_op <= eeprom_pkg::BIT_WRITE;
              byte_tx <= wdata_q;
            end else begin
              state   <= S_RSTART;
              byte_op <= eeprom_pkg::BIT_START;
            end
          end
          S_WR_DATA: if (byte_done) begin
            state   <= S_STOP;
            byte_go <= 1'b1;
            byte_op <= eeprom_pkg::BIT_STOP;
          end
          S_RSTART: if (byte_done) begin
            state   <= S_CTRL_RD;
            byte_go <= 1'b1;
            byte_op <= eeprom_pkg::BIT_WRITE;
            byte_tx <= ctrl_rd;
          end
          S_CTRL_RD: if (byte_done) begin
            state   <= S_RD_DATA;
            byte_go <= 1'b1;
            byte_op <= eeprom_pkg::BIT_READ;
            byte_tx <= RX_LAST;  // single byte read, so nack it
          end
          S_RD_DATA: if (byte_done) begin
            state   <= S_STOP;
            byte_go <= 1'b1;
            byte_op <= eeprom_pkg::BIT_STOP;
          end
          S_STOP: if (byte_done) state <= S_RESPOND;
          S_RESPOND: begin
            rsp_valid <= 1'b1;
            state     <= S_IDLE;
          end
          default: state <= S_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- src/i2c_bit_engine.sv
`timescale 1ns/10ps
`default_nettype none

// CLK_DIV must be 2 or more so bit_done can lead the end of the bit
module i2c_bit_engine #(
  parameter int unsigned CLK_DIV = 4
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                bit_go,
  input  eeprom_pkg::bit_op_t bit_op,
  input  logic                bit_tx,
  output logic                bit_done,
  output logic                bit_rx,
  output logic                scl,
  output logic                sda_pull,
  input  logic                sda_in
);

  localparam int unsigned QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam logic [QW-1:0] Q_LAST = QW'(CLK_DIV - 1);
  localparam logic [QW-1:0] Q_DONE = QW'(CLK_DIV - 2);

  // one quarter of the scl period per state
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_Q0,
    ST_Q1,
    ST_Q2,
    ST_Q3
  } state_t;

  state_t              state;
  logic [QW-1:0]       qcnt;
  eeprom_pkg::bit_op_t op_q;
  logic                q_end;
  logic                launch;

  assign q_end  = (qcnt == Q_LAST);
  assign launch = bit_go && (state == ST_IDLE || (state == ST_Q3 && q_end));

  // pulse in the second to last cycle of the op
  assign bit_done = (state == ST_Q3) && (qcnt == Q_DONE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      qcnt     <= '0;
      op_q     <= eeprom_pkg::BIT_STOP;
      scl      <= 1'b1;
      sda_pull <= 1'b0;
      bit_rx   <= 1'b1;
    end else begin
      if (launch || state == ST_IDLE || q_end)
        qcnt <= '0;
      else
        qcnt <= qcnt + 1'b1;

      if (launch) begin
        state <= ST_Q0;
        op_q  <= bit_op;
        // scl is low here, except from idle where sda is already released
        case (bit_op)
          eeprom_pkg::BIT_START: sda_pull <= 1'b0;
          eeprom_pkg::BIT_STOP:  sda_pull <= 1'b1;
          eeprom_pkg::BIT_WRITE: sda_pull <= !bit_tx;
          default:               sda_pull <= 1'b0;  // read, let the slave drive
        endcase
      end else if (q_end) begin
        case (state)
          ST_Q0: begin
            state <= ST_Q1;
            scl   <= 1'b1;
          end
          ST_Q1: begin
            state  <= ST_Q2;
            bit_rx <= sda_in;  // middle of scl high
            if (op_q == eeprom_pkg::BIT_START)
              sda_pull <= 1'b1;  // sda falls, scl high
            else if (op_q == eeprom_pkg::BIT_STOP)
              sda_pull <= 1'b0;  // sda rises, scl high
          end
          ST_Q2: begin
            state <= ST_Q3;
            if (op_q != eeprom_pkg::BIT_STOP)
              scl <= 1'b0;
          end
          ST_Q3: state <= ST_IDLE;  // no follow-on op, hold the lines
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- src/i2c_byte_shift.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_shift (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 byte_go,
  input  eeprom_pkg::bit_op_t  byte_op,
  input  eeprom_pkg::ee_byte_t byte_tx,
  output logic                 byte_done,
  output eeprom_pkg::ee_byte_t byte_rx,
  output logic                 ack_seen,
  output logic                 bit_go,
  output eeprom_pkg::bit_op_t  bit_op,
  output logic                 bit_tx,
  input  logic                 bit_done,
  input  logic                 bit_rx
);

  logic                 busy;
  eeprom_pkg::bit_op_t  op_q;
  eeprom_pkg::ee_byte_t shreg;
  logic [3:0]           bcnt;    // 0..7 data, 8 ack slot
  logic                 ack_tx;
  logic                 is_cond;
  logic                 last_bit;

  assign is_cond  = (op_q == eeprom_pkg::BIT_START) || (op_q == eeprom_pkg::BIT_STOP);
  assign last_bit = is_cond || (bcnt == 4'd8);

  // bit_done comes one cycle before the bit ends, so the next go lands on time
  assign byte_done = busy && bit_done && last_bit;
  assign byte_rx   = shreg;
  assign ack_seen  = (op_q == eeprom_pkg::BIT_WRITE) ? !bit_rx : 1'b1;

  always_ff @(posedge clk) begin
    if (byte_go) begin
      shreg  <= byte_tx;
      ack_tx <= byte_tx[0];
    end else if (busy && bit_done && !last_bit) begin
      shreg <= {shreg[6:0], (op_q == eeprom_pkg::BIT_READ) ? bit_rx : 1'b0};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy   <= 1'b0;
      op_q   <= eeprom_pkg::BIT_STOP;
      bcnt   <= '0;
      bit_go <= 1'b0;
      bit_op <= eeprom_pkg::BIT_STOP;
      bit_tx <= 1'b1;
    end else begin
      bit_go <= 1'b0;
      if (byte_go) begin
        busy   <= 1'b1;
        op_q   <= byte_op;
        bcnt   <= '0;
        bit_go <= 1'b1;
        bit_op <= byte_op;  // first bit uses the same code as the byte
        bit_tx <= byte_tx[7];
      end else if (busy && bit_done) begin
        if (last_bit) begin
          busy <= 1'b0;
        end else begin
          bcnt   <= bcnt + 4'd1;
          bit_go <= 1'b1;
          if (bcnt == 4'd7) begin
            // ack slot flips direction
            bit_op <= (op_q == eeprom_pkg::BIT_WRITE) ? eeprom_pkg::BIT_READ
                                                       : eeprom_pkg::BIT_WRITE;
            bit_tx <= ack_tx;
          end else begin
            bit_op <= op_q;
            bit_tx <= shreg[6];  // msb first
          end
        end
      end
    end
  end

endmodule

`default_nettype wire
